/* logic/arch_map_table.sv */
// Architected map table: committed mapping, updated at retirement, next-state snapshot
`timescale 1ns/1ps
`default_nettype none

module arch_map_table import rename_pkg::*; (
    input  logic      clock,
    input  logic      rst_n,

    // Retiring instruction from the ROB head
    input  retire_t   retire,

    // Committed map as it stands after this edge
    output arch_map_t snapshot_next
);

    arch_map_t committed_q;

    //////////////////////////////
    // Next committed state
    //////////////////////////////

    // Includes the retiring write, so a mispredicting
    // branch with a destination restores its own result
    always_comb begin
        snapshot_next = committed_q;
        if (retire.valid && retire.has_dest) begin
            snapshot_next[retire.rd] = retire.dest_tag;
        end
    end

    //////////////////////////////
    // State
    //////////////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            committed_q <= RESET_MAP;
        end else begin
            committed_q <= snapshot_next;
        end
    end

endmodule

`default_nettype wire

/* logic/free_list.sv */
// Free list: bitmap of free physical tags, lowest-first pick, rebuild on recovery
`timescale 1ns/1ps
`default_nettype none

module free_list import rename_pkg::*; (
    input  logic      clock,
    input  logic      rst_n,

    // Allocation for a renamed destination
    input  logic      alloc_en,
    output phys_tag_t alloc_tag,

    // Release of a retired old tag
    input  logic      free_en,
    input  phys_tag_t free_tag,

    // Rebuild from the committed map
    input  logic      restore_en,
    input  arch_map_t restore_map
);

    phys_mask_t free_q;
    phys_mask_t free_d;
    phys_mask_t restore_free;

    //////////////////////////////
    // Lowest free tag
    //////////////////////////////

    // Scan downwards so the last hit is the lowest set bit
    always_comb begin
        alloc_tag = '0;
        for (int i = PHYS_REGS - 1; i >= 0; i--) begin
            if (free_q[i]) begin
                alloc_tag = phys_tag_t'(i);
            end
        end
    end

    //////////////////////////////
    // Rebuild mask
    //////////////////////////////

    // Everything free except tags the committed map still points at
    always_comb begin
        restore_free = '1;
        for (int r = 0; r < ARCH_REGS; r++) begin
            restore_free[restore_map[r]] = 1'b0;
        end
    end

    //////////////////////////////
    // Bitmap update
    //////////////////////////////

    always_comb begin
        free_d = free_q;
        if (alloc_en) begin
            free_d[alloc_tag] = 1'b0;
        end
        // Freed tag becomes visible next cycle
        if (free_en) begin
            free_d[free_tag] = 1'b1;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            free_q <= RESET_FREE;
        end else if (restore_en) begin
            free_q <= restore_free;
        end else begin
            free_q <= free_d;
        end
    end

endmodule

`default_nettype wire

/* logic/map_table.sv */
// Speculative map table: source and old-tag lookup, rename write, full restore
`timescale 1ns/1ps
`default_nettype none

module map_table import rename_pkg::*; (
    input  logic      clock,
    input  logic      rst_n,

    // Lookups for the instruction being dispatched
    input  arch_reg_t rs1,
    input  arch_reg_t rs2,
    input  arch_reg_t rd,
    output phys_tag_t src1_tag,
    output phys_tag_t src2_tag,
    output phys_tag_t old_tag,

    // New mapping for rd
    input  logic      write_en,
    input  phys_tag_t write_tag,

    // Recovery from the committed map
    input  logic      restore_en,
    input  arch_map_t restore_map
);

    arch_map_t map_q;

    //////////////////////////////
    // Lookup
    //////////////////////////////

    // Reads see the table before this cycle's write
    assign src1_tag = map_q[rs1];
    assign src2_tag = map_q[rs2];
    assign old_tag  = map_q[rd];

    //////////////////////////////
    // Update
    //////////////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            map_q <= RESET_MAP;
        end else if (restore_en) begin
            // Restore wins over a same-cycle rename
            map_q <= restore_map;
        end else if (write_en) begin
            map_q[rd] <= write_tag;
        end
    end

endmodule

`default_nettype wire

/* logic/rename_core.sv */
// Rename core top: map tables, free list, ROB, registered rename, retire and credit
`timescale 1ns/1ps
`default_nettype none

module rename_core import rename_pkg::*; (
    input  logic          clock,
    input  logic          rst_n,

    input  dispatch_req_t dispatch,
    input  complete_t     complete,

    output dispatch_rsp_t rename,
    output retire_t       retire,
    output credit_t       credit_return
);

    phys_tag_t     src1_tag;
    phys_tag_t     src2_tag;
    phys_tag_t     map_old_tag;
    phys_tag_t     alloc_tag;
    phys_tag_t     dest_tag;
    phys_tag_t     old_tag;
    logic          alloc_en;
    logic          flush;
    rob_idx_t      rob_idx;
    retire_t       rob_retire;
    credit_t       flushed_count;
    arch_map_t     snapshot_next;
    dispatch_rsp_t rename_d;

    // No destination, no tags recorded
    assign dest_tag = dispatch.has_dest ? alloc_tag : '0;
    assign old_tag  = dispatch.has_dest ? map_old_tag : '0;

    //////////////////////////////
    // Blocks
    //////////////////////////////

    map_table map_table_i (
        .clock       (clock),
        .rst_n       (rst_n),
        .rs1         (dispatch.rs1),
        .rs2         (dispatch.rs2),
        .rd          (dispatch.rd),
        .src1_tag    (src1_tag),
        .src2_tag    (src2_tag),
        .old_tag     (map_old_tag),
        .write_en    (alloc_en),
        .write_tag   (alloc_tag),
        .restore_en  (flush),
        .restore_map (snapshot_next)
    );

    // Old tag goes back only for instructions that renamed a register
    free_list free_list_i (
        .clock       (clock),
        .rst_n       (rst_n),
        .alloc_en    (alloc_en),
        .alloc_tag   (alloc_tag),
        .free_en     (rob_retire.valid && rob_retire.has_dest),
        .free_tag    (rob_retire.old_tag),
        .restore_en  (flush),
        .restore_map (snapshot_next)
    );

    reorder_buffer reorder_buffer_i (
        .clock         (clock),
        .rst_n         (rst_n),
        .dispatch      (dispatch),
        .alloc_tag     (dest_tag),
        .old_tag       (old_tag),
        .alloc_en      (alloc_en),
        .rob_idx       (rob_idx),
        .complete      (complete),
        .retire        (rob_retire),
        .flush         (flush),
        .flushed_count (flushed_count)
    );

    arch_map_table arch_map_table_i (
        .clock         (clock),
        .rst_n         (rst_n),
        .retire        (rob_retire),
        .snapshot_next (snapshot_next)
    );

    //////////////////////////////
    // Output registers
    //////////////////////////////

    // Dispatch caught by a flush gets no response
    always_comb begin
        rename_d.valid    = dispatch.valid && !flush;
        rename_d.rob_idx  = rob_idx;
        rename_d.src1_tag = src1_tag;
        rename_d.src2_tag = src2_tag;
        rename_d.dest_tag = dest_tag;
        rename_d.old_tag  = old_tag;
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            rename        <= '0;
            retire        <= '0;
            credit_return <= '0;
        end else begin
            rename <= rename_d;
            retire <= rob_retire;
            // One for the retiring slot, plus whatever the flush freed
            credit_return <= rob_retire.valid ? credit_t'(credit_t'(1) + flushed_count) : '0;
        end
    end

endmodule

`default_nettype wire

/* logic/rename_pkg.sv */
// Rename package: sizes, tag and index types, reset values, port structs
`default_nettype none

package rename_pkg;

    //////////////////////////////
    // Sizes
    //////////////////////////////

    localparam int ARCH_REGS = 8;
    localparam int ROB_DEPTH = 8;
    // One spare tag per ROB slot, so allocation never runs dry under credit
    localparam int PHYS_REGS = ARCH_REGS + ROB_DEPTH;

    localparam int ARCH_W   = $clog2(ARCH_REGS);
    localparam int TAG_W    = $clog2(PHYS_REGS);
    localparam int ROB_W    = $clog2(ROB_DEPTH);
    localparam int CREDIT_W = $clog2(ROB_DEPTH + 1);

    //////////////////////////////
    // Vector types
    //////////////////////////////

    typedef logic [ARCH_W-1:0]   arch_reg_t;
    typedef logic [TAG_W-1:0]    phys_tag_t;
    typedef logic [ROB_W-1:0]    rob_idx_t;
    typedef logic [CREDIT_W-1:0] credit_t;
    // Whole map, indexed by architectural register
    typedef phys_tag_t [ARCH_REGS-1:0] arch_map_t;
    // One bit per physical tag
    typedef logic [PHYS_REGS-1:0] phys_mask_t;

    // Identity map, register r on tag r
    function automatic arch_map_t identity_map();
        arch_map_t map;
        for (int r = 0; r < ARCH_REGS; r++) begin
            map[r] = phys_tag_t'(r);
        end
        return map;
    endfunction

    localparam arch_map_t  RESET_MAP  = identity_map();
    // Tags above the architectural range start out free
    localparam phys_mask_t RESET_FREE = {{ROB_DEPTH{1'b1}}, {ARCH_REGS{1'b0}}};

    //////////////////////////////
    // Port structs
    //////////////////////////////

    typedef struct packed {
        logic      valid;
        logic      has_dest;
        arch_reg_t rd;
        arch_reg_t rs1;
        arch_reg_t rs2;
    } dispatch_req_t;

    typedef struct packed {
        logic      valid;
        rob_idx_t  rob_idx;
        phys_tag_t src1_tag;
        phys_tag_t src2_tag;
        phys_tag_t dest_tag;
        phys_tag_t old_tag;
    } dispatch_rsp_t;

    typedef struct packed {
        logic     valid;
        rob_idx_t rob_idx;
        logic     mispredict;
    } complete_t;

    typedef struct packed {
        logic      valid;
        logic      has_dest;
        arch_reg_t rd;
        phys_tag_t dest_tag;
        phys_tag_t old_tag;
        logic      mispredict;
    } retire_t;

endpackage

`default_nettype wire

/* logic/reorder_buffer.sv */
// Reorder buffer: in-order allocation, completion marking, head retirement, flush
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer import rename_pkg::*; (
    input  logic          clock,
    input  logic          rst_n,

    // Dispatch side
    input  dispatch_req_t dispatch,
    input  phys_tag_t     alloc_tag,
    input  phys_tag_t     old_tag,
    output logic          alloc_en,
    output rob_idx_t      rob_idx,

    // Completion from outside, bare slot index
    input  complete_t     complete,

    // Retirement and recovery
    output retire_t       retire,
    output logic          flush,
    output credit_t       flushed_count
);

    // Rename record written at dispatch
    typedef struct packed {
        logic      has_dest;
        arch_reg_t rd;
        phys_tag_t dest_tag;
        phys_tag_t old_tag;
    } rob_entry_t;

    rob_entry_t           entry_q [ROB_DEPTH];
    rob_entry_t           new_entry;
    logic [ROB_DEPTH-1:0] done_q;
    logic [ROB_DEPTH-1:0] mispredict_q;
    rob_idx_t             head_q;
    rob_idx_t             tail_q;
    credit_t              count_q;
    logic                 push;
    logic                 pop;

    //////////////////////////////
    // Allocation
    //////////////////////////////

    // Dispatch in the flush cycle is dropped and counted as flushed
    assign push     = dispatch.valid && !flush;
    assign alloc_en = push && dispatch.has_dest;
    assign rob_idx  = tail_q;

    always_comb begin
        new_entry.has_dest = dispatch.has_dest;
        new_entry.rd       = dispatch.rd;
        new_entry.dest_tag = alloc_tag;
        new_entry.old_tag  = old_tag;
    end

    always_ff @(posedge clock) begin
        if (push) begin
            entry_q[tail_q] <= new_entry;
        end
        if (complete.valid) begin
            mispredict_q[complete.rob_idx] <= complete.mispredict;
        end
    end

    //////////////////////////////
    // Head retirement
    //////////////////////////////

    always_comb begin
        retire.valid      = (count_q != '0) && done_q[head_q];
        retire.has_dest   = entry_q[head_q].has_dest;
        retire.rd         = entry_q[head_q].rd;
        retire.dest_tag   = entry_q[head_q].dest_tag;
        retire.old_tag    = entry_q[head_q].old_tag;
        retire.mispredict = mispredict_q[head_q];
    end

    assign pop   = retire.valid;
    assign flush = retire.valid && retire.mispredict;

    // Younger entries plus any dispatch lost at this edge
    assign flushed_count = flush ? credit_t'(count_q - credit_t'(1) + credit_t'(dispatch.valid))
                                 : '0;

    //////////////////////////////
    // Done bits
    //////////////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            done_q <= '0;
        end else if (flush) begin
            // Head leaves and every younger slot is discarded
            done_q <= '0;
        end else begin
            if (pop) begin
                done_q[head_q] <= 1'b0;
            end
            if (complete.valid) begin
                done_q[complete.rob_idx] <= 1'b1;
            end
            if (push) begin
                done_q[tail_q] <= 1'b0;
            end
        end
    end

    //////////////////////////////
    // Pointers
    //////////////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush) begin
            // Empty, restarting just past the retired branch
            head_q  <= head_q + rob_idx_t'(1);
            tail_q  <= head_q + rob_idx_t'(1);
            count_q <= '0;
        end else begin
            if (push) begin
                tail_q <= tail_q + rob_idx_t'(1);
            end
            if (pop) begin
                head_q <= head_q + rob_idx_t'(1);
            end
            count_q <= count_q + credit_t'(push) - credit_t'(pop);
        end
    end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the rename core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=rename_core_sim

if ! verilator --binary --timing --assert -f src.f --top-module rename_core_tb -o "$BIN"; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/"$BIN" > "$LOG" 2>&1; then
    cat "$LOG"
    echo "Simulation exited with an error"
    exit 1
fi

cat "$LOG"

if grep -q "^STATUS: PASS$" "$LOG"; then
    exit 0
else
    echo "Pass line not found in $LOG"
    exit 1
fi

/* sim/rename_core_props.sv */
// Rename core port properties and their bind to the top level
`timescale 1ns/1ps
`default_nettype none

module rename_core_props import rename_pkg::*; (
    input logic          clock,
    input logic          rst_n,
    input dispatch_req_t dispatch,
    input dispatch_rsp_t rename,
    input retire_t       retire,
    input credit_t       credit_return
);

    //////////////////////////////
    // Dispatch to rename
    //////////////////////////////

    // Every response needs a request one cycle before
    property rename_follows_dispatch;
        @(posedge clock) disable iff (!rst_n)
            rename.valid |-> $past(dispatch.valid);
    endproperty

    rename_follows_dispatch_a : assert property (rename_follows_dispatch)
        else $error("rename valid without a dispatch one cycle earlier");

    //////////////////////////////
    // Credits
    //////////////////////////////

    // Never more than the whole ROB back at once
    property credit_in_range;
        @(posedge clock) disable iff (!rst_n)
            credit_return <= credit_t'(ROB_DEPTH);
    endproperty

    credit_in_range_a : assert property (credit_in_range)
        else $error("credit_return above the ROB depth");

    //////////////////////////////
    // Reset
    //////////////////////////////

    property retire_idle_after_reset;
        @(posedge clock) $rose(rst_n) |-> !retire.valid;
    endproperty

    retire_idle_after_reset_a : assert property (retire_idle_after_reset)
        else $error("retire valid high right after reset");

endmodule

bind rename_core rename_core_props rename_core_props_i (
    .clock         (clock),
    .rst_n         (rst_n),
    .dispatch      (dispatch),
    .rename        (rename),
    .retire        (retire),
    .credit_return (credit_return)
);

`default_nettype wire

/* sim/rename_core_tb.sv */
// Rename core testbench: reference model, directed tests, compare tasks, watchdog
`timescale 1ns/1ps
`default_nettype none

module rename_core_tb import rename_pkg::*; ();

    localparam int CLK_PERIOD   = 4;
    localparam logic [31:0] SEED = 32'h482268ca;
    localparam int WAIT_LIMIT   = 20;
    localparam int DRAIN_LIMIT  = 40;
    // Rough cycle budget per test
    localparam int WATCHDOG_CYCLES = 60 + 40 + 30 + 80 + 50 + 100;

    localparam dispatch_req_t NO_DISPATCH = '0;
    localparam complete_t     NO_COMPLETE = '0;

    // One in-flight instruction as the model sees it
    typedef struct packed {
        rob_idx_t  idx;
        logic      has_dest;
        arch_reg_t rd;
        phys_tag_t dest_tag;
        phys_tag_t old_tag;
        logic      done;
        logic      mispredict;
    } model_entry_t;

    logic          clock;
    logic          rst_n;
    dispatch_req_t dispatch;
    complete_t     complete;
    dispatch_rsp_t rename;
    retire_t       retire;
    credit_t       credit_return;

    // Model state
    arch_map_t     spec_map;
    arch_map_t     commit_map;
    phys_mask_t    free_mask;
    rob_idx_t      head_idx;
    rob_idx_t      tail_idx;
    model_entry_t  inflight [$];
    dispatch_rsp_t exp_rename;
    retire_t       exp_retire;
    credit_t       exp_credit;

    int            credits;
    logic [31:0]   lfsr_q;
    string         test_name;
    int            rename_errors;
    int            retire_errors;
    int            credit_errors;
    int            other_errors;

    rename_core rename_core_i (
        .clock         (clock),
        .rst_n         (rst_n),
        .dispatch      (dispatch),
        .complete      (complete),
        .rename        (rename),
        .retire        (retire),
        .credit_return (credit_return)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    //////////////////////////////
    // Random register numbers
    //////////////////////////////

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic feedback;
        feedback = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], feedback};
    endfunction

    function automatic arch_reg_t random_reg();
        arch_reg_t r;
        for (int b = 0; b < ARCH_W; b++) begin
            lfsr_q = lfsr_next(lfsr_q);
            r[b]   = lfsr_q[0];
        end
        return r;
    endfunction

    //////////////////////////////
    // Reference model
    //////////////////////////////

    function automatic phys_tag_t lowest_free(input phys_mask_t m);
        phys_tag_t tag;
        logic      found;
        tag   = '0;
        found = 1'b0;
        for (int i = 0; i < PHYS_REGS; i++) begin
            if (!found && m[i]) begin
                tag   = phys_tag_t'(i);
                found = 1'b1;
            end
        end
        return tag;
    endfunction

    task automatic reset_model();
        for (int r = 0; r < ARCH_REGS; r++) begin
            spec_map[r]   = phys_tag_t'(r);
            commit_map[r] = phys_tag_t'(r);
        end
        // Upper half of the pool free after reset
        free_mask = '0;
        for (int t = ARCH_REGS; t < PHYS_REGS; t++) begin
            free_mask[t] = 1'b1;
        end
        head_idx = '0;
        tail_idx = '0;
        inflight.delete();
        exp_rename = '0;
        exp_retire = '0;
        exp_credit = '0;
    endtask

    // Predict the outputs after the edge that samples d and c
    task automatic predict_edge(input dispatch_req_t d, input complete_t c);
        model_entry_t head;
        model_entry_t e;
        logic         retiring;
        logic         flushing;
        int           younger;
        retiring   = (inflight.size() > 0) && inflight[0].done;
        flushing   = retiring && inflight[0].mispredict;
        exp_rename = '0;
        exp_retire = '0;
        exp_credit = '0;
        // Lookup uses the map before this edge
        if (d.valid && !flushing) begin
            exp_rename.valid    = 1'b1;
            exp_rename.rob_idx  = tail_idx;
            exp_rename.src1_tag = spec_map[d.rs1];
            exp_rename.src2_tag = spec_map[d.rs2];
            if (d.has_dest) begin
                exp_rename.dest_tag = lowest_free(free_mask);
                exp_rename.old_tag  = spec_map[d.rd];
            end
        end
        if (retiring) begin
            head = inflight.pop_front();
            exp_retire.valid      = 1'b1;
            exp_retire.has_dest   = head.has_dest;
            exp_retire.rd         = head.rd;
            exp_retire.dest_tag   = head.dest_tag;
            exp_retire.old_tag    = head.old_tag;
            exp_retire.mispredict = head.mispredict;
            exp_credit            = credit_t'(1);
            if (head.has_dest) begin
                commit_map[head.rd]     = head.dest_tag;
                free_mask[head.old_tag] = 1'b1;
            end
            head_idx = head_idx + rob_idx_t'(1);
        end
        if (flushing) begin
            // Younger entries and a same-edge dispatch all come back
            younger    = inflight.size() + int'(d.valid);
            exp_credit = credit_t'(1 + younger);
            inflight.delete();
            spec_map  = commit_map;
            free_mask = '1;
            for (int r = 0; r < ARCH_REGS; r++) begin
                free_mask[commit_map[r]] = 1'b0;
            end
            tail_idx = head_idx;
        end else begin
            if (c.valid) begin
                foreach (inflight[i]) begin
                    if (inflight[i].idx == c.rob_idx) begin
                        inflight[i].done       = 1'b1;
                        inflight[i].mispredict = c.mispredict;
                    end
                end
            end
            if (d.valid) begin
                e.idx        = tail_idx;
                e.has_dest   = d.has_dest;
                e.rd         = d.rd;
                e.dest_tag   = exp_rename.dest_tag;
                e.old_tag    = exp_rename.old_tag;
                e.done       = 1'b0;
                e.mispredict = 1'b0;
                inflight.push_back(e);
                if (d.has_dest) begin
                    free_mask[e.dest_tag] = 1'b0;
                    spec_map[d.rd]        = e.dest_tag;
                end
                tail_idx = tail_idx + rob_idx_t'(1);
            end
        end
    endtask

    //////////////////////////////
    // Compare tasks
    //////////////////////////////

    // Fields of an idle response are don't-care
    task automatic rename_compare(input string test, input dispatch_rsp_t expected,
                                  input dispatch_rsp_t actual);
        logic bad;
        bad = expected.valid ? (actual !== expected) : (actual.valid !== 1'b0);
        if (bad) begin
            rename_errors++;
            $display("ERROR %s rename: expected %h, actual %h", test, expected, actual);
        end
    endtask

    task automatic retire_compare(input string test, input retire_t expected,
                                  input retire_t actual);
        logic bad;
        bad = expected.valid ? (actual !== expected) : (actual.valid !== 1'b0);
        if (bad) begin
            retire_errors++;
            $display("ERROR %s retire: expected %h, actual %h", test, expected, actual);
        end
    endtask

    task automatic credit_compare(input string test, input credit_t expected,
                                  input credit_t actual);
        if (actual !== expected) begin
            credit_errors++;
            $display("ERROR %s credit_return: expected %0d, actual %0d", test, expected, actual);
        end
    endtask

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    // One clock: drive, then check what the previous inputs produced
    task automatic step(input dispatch_req_t d, input complete_t c);
        @(posedge clock);
        dispatch <= d;
        complete <= c;
        if (d.valid) begin
            credits--;
        end
        @(negedge clock);
        rename_compare(test_name, exp_rename, rename);
        retire_compare(test_name, exp_retire, retire);
        credit_compare(test_name, exp_credit, credit_return);
        credits += int'(credit_return);
        predict_edge(d, c);
        if (credits > ROB_DEPTH || credits + inflight.size() > ROB_DEPTH) begin
            other_errors++;
            $display("%s: more instructions in flight than the ROB holds", test_name);
        end
    endtask

    // Dispatch once a credit is held
    task automatic issue(input logic has_dest, input arch_reg_t rd,
                         input arch_reg_t rs1, input arch_reg_t rs2);
        dispatch_req_t d;
        int            waited;
        waited = 0;
        while (credits == 0 && waited < WAIT_LIMIT) begin
            step(NO_DISPATCH, NO_COMPLETE);
            waited++;
        end
        if (credits == 0) begin
            other_errors++;
            $display("%s: no dispatch credit came back", test_name);
        end else begin
            d.valid    = 1'b1;
            d.has_dest = has_dest;
            d.rd       = rd;
            d.rs1      = rs1;
            d.rs2      = rs2;
            step(d, NO_COMPLETE);
        end
    endtask

    task automatic finish_slot(input rob_idx_t idx, input logic mispredict);
        complete_t c;
        c.valid      = 1'b1;
        c.rob_idx    = idx;
        c.mispredict = mispredict;
        step(NO_DISPATCH, c);
    endtask

    // Complete what is left, oldest first, until the last retirement shows up
    task automatic drain();
        int   cycles;
        int   pos;
        logic busy;
        cycles = 0;
        busy   = 1'b1;
        while (busy && cycles < DRAIN_LIMIT) begin
            pos = -1;
            foreach (inflight[i]) begin
                if (pos < 0 && !inflight[i].done) begin
                    pos = i;
                end
            end
            if (pos >= 0) begin
                finish_slot(inflight[pos].idx, 1'b0);
            end else begin
                step(NO_DISPATCH, NO_COMPLETE);
            end
            cycles++;
            busy = (inflight.size() > 0) || exp_retire.valid || (exp_credit != '0);
        end
        if (busy) begin
            other_errors++;
            $display("%s: ROB did not drain within %0d cycles", test_name, DRAIN_LIMIT);
        end else if (credits != ROB_DEPTH) begin
            other_errors++;
            $display("%s: dispatcher holds %0d credits after drain", test_name, credits);
        end
    endtask

    //////////////////////////////
    // Directed tests
    //////////////////////////////

    task automatic reset_map_order();
        test_name = "reset_map";
        // Identity map seen by sources, no allocation yet
        for (int r = 0; r < ARCH_REGS; r++) begin
            issue(1'b0, '0, arch_reg_t'(r), arch_reg_t'(ARCH_REGS - 1 - r));
        end
        drain();
        // Upper tags handed out in order
        for (int r = 0; r < ARCH_REGS; r++) begin
            issue(1'b1, arch_reg_t'(r), arch_reg_t'(r), random_reg());
        end
        drain();
    endtask

    task automatic dependent_chain();
        arch_reg_t prev;
        arch_reg_t rd;
        test_name = "dependent_chain";
        prev = random_reg();
        for (int i = 0; i < 6; i++) begin
            rd = random_reg();
            issue(1'b1, rd, prev, random_reg());
            prev = rd;
        end
        // rd equal to rs1
        issue(1'b1, prev, prev, prev);
        drain();
    endtask

    task automatic out_of_order_retire();
        rob_idx_t slots [4];
        test_name = "out_of_order";
        for (int i = 0; i < 4; i++) begin
            issue(1'b1, random_reg(), random_reg(), random_reg());
        end
        foreach (slots[i]) begin
            slots[i] = inflight[i].idx;
        end
        finish_slot(slots[2], 1'b0);
        finish_slot(slots[0], 1'b0);
        finish_slot(slots[3], 1'b0);
        finish_slot(slots[1], 1'b0);
        drain();
    endtask

    task automatic credit_limit();
        test_name = "credit_limit";
        for (int i = 0; i < ROB_DEPTH; i++) begin
            issue(1'b1, random_reg(), random_reg(), random_reg());
        end
        if (credits != 0) begin
            other_errors++;
            $display("%s: dispatcher still holds credits with a full ROB", test_name);
        end
        // Next dispatch has to wait for the oldest to retire
        finish_slot(inflight[0].idx, 1'b0);
        issue(1'b1, random_reg(), random_reg(), random_reg());
        drain();
        // Refill, freed tags come back lowest first
        for (int i = 0; i < ROB_DEPTH; i++) begin
            issue(1'b1, random_reg(), random_reg(), random_reg());
        end
        drain();
    endtask

    task automatic mispredict_recovery();
        rob_idx_t slots [2];
        test_name = "mispredict";
        for (int i = 0; i < 5; i++) begin
            issue(1'b1, random_reg(), random_reg(), random_reg());
        end
        slots[0] = inflight[0].idx;
        slots[1] = inflight[1].idx;
        finish_slot(slots[0], 1'b0);
        finish_slot(slots[1], 1'b1);
        // Lands on the flush edge and is dropped
        issue(1'b1, random_reg(), random_reg(), random_reg());
        // Sources from the committed map, tags from the rebuilt bitmap
        for (int r = 0; r < 4; r++) begin
            issue(1'b1, random_reg(), arch_reg_t'(r), arch_reg_t'(r + 4));
        end
        drain();
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        dispatch      = '0;
        complete      = '0;
        rst_n         = 1'b0;
        lfsr_q        = SEED;
        credits       = ROB_DEPTH;
        rename_errors = 0;
        retire_errors = 0;
        credit_errors = 0;
        other_errors  = 0;
        test_name     = "reset";
        reset_model();
        repeat (2) @(posedge clock);
        rst_n <= 1'b1;

        reset_map_order();
        dependent_chain();
        out_of_order_retire();
        credit_limit();
        mispredict_recovery();

        $display("errors: rename %0d, retire %0d, credit %0d, other %0d",
                 rename_errors, retire_errors, credit_errors, other_errors);
        if (rename_errors + retire_errors + credit_errors + other_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Hung handshake ends the run here
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
logic/rename_pkg.sv
logic/map_table.sv
logic/free_list.sv
logic/reorder_buffer.sv
logic/arch_map_table.sv
logic/rename_core.sv
sim/rename_core_props.sv
sim/rename_core_tb.sv
